//--- src/soc_pkg.sv
// ----------------------------------------------------------------------
// shared constants, bus address views and stream structs for the SoC
// ----------------------------------------------------------------------

package soc_pkg;

	// memory and link sizing
	localparam int ram_addr_width = 17;
	localparam int clks_per_bit   = 8;
	localparam int fifo_depth     = 8;

	// host command opcodes
	localparam logic [7:0] op_break   = 8'h01;
	localparam logic [7:0] op_release = 8'h02;
	localparam logic [7:0] op_read    = 8'h03;
	localparam logic [7:0] op_write   = 8'h04;

	// io selects, low address bits inside the io region
	localparam logic [2:0] io_sel_tx     = 3'd0;
	localparam logic [2:0] io_sel_status = 3'd1;

	typedef struct packed {
		logic                      region;
		logic [ram_addr_width-1:0] offset;
	} ram_view_t;

	typedef struct packed {
		logic [1:0]                region;
		logic [ram_addr_width-5:0] unused;
		logic [2:0]                sel;
	} io_view_t;

	// one 18 bit bus address, read as a ram offset or as an io select
	typedef union packed {
		ram_view_t ram_view;
		io_view_t  io_view;
	} bus_addr_u;

	typedef struct packed {
		bus_addr_u  addr;
		logic       wr;
		logic [7:0] data;
	} mem_req_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} byte_stream_t;

endpackage

//--- src/uart_rx.sv
// ----------------------------------------------------------------------
// uart receiver, samples 8N1 frames mid-bit and emits one byte pulse
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module uart_rx
(
	input  logic                  clk,
	input  logic                  btnC,
	input  logic                  rx,
	output soc_pkg::byte_stream_t rx_byte
);

	localparam int cnt_w = $clog2(soc_pkg::clks_per_bit);
	localparam logic [cnt_w-1:0] half = cnt_w'(soc_pkg::clks_per_bit / 2 - 1);
	localparam logic [cnt_w-1:0] full = cnt_w'(soc_pkg::clks_per_bit - 1);

	typedef enum logic [1:0] {s_idle, s_start, s_data, s_stop} state_t;

	state_t           state;
	logic             rx_meta;
	logic             rx_sync;
	logic [cnt_w-1:0] cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;
	logic             rx_valid;

	// shift holds still from the last data bit until the next frame
	assign rx_byte = '{valid: rx_valid, data: shift};

	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			rx_meta  <= 1'b1;
			rx_sync  <= 1'b1;
			state    <= s_idle;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_meta  <= rx;
			rx_sync  <= rx_meta;
			rx_valid <= 1'b0;
			case (state)
				s_idle:
					if (!rx_sync)
					begin
						state <= s_start;
						cnt   <= '0;
					end
				s_start:
					if (cnt == half)
					begin
						cnt     <= '0;
						bit_idx <= '0;
						// a start bit gone high by mid-bit was a glitch
						state   <= rx_sync ? s_idle : s_data;
					end
					else
						cnt <= cnt + 1'b1;
				s_data:
					if (cnt == full)
					begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= s_stop;
					end
					else
						cnt <= cnt + 1'b1;
				default:
					if (cnt == full)
					begin
						state    <= s_idle;
						// framing error drops the byte
						rx_valid <= rx_sync;
					end
					else
						cnt <= cnt + 1'b1;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk)
	begin
		if (state == s_data && cnt == full)
			shift <= {rx_sync, shift[7:1]};
	end

endmodule

//--- src/cmd_fifo.sv
// ----------------------------------------------------------------------
// byte fifo between the uart receiver and the host engine
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module cmd_fifo
(
	input  logic                  clk,
	input  logic                  btnC,
	input  soc_pkg::byte_stream_t in_byte,
	output logic                  out_valid,
	output logic [7:0]            out_data,
	input  logic                  out_ready
);

	localparam int ptr_w = $clog2(soc_pkg::fifo_depth);
	localparam int cnt_w = ptr_w + 1;
	localparam logic [ptr_w-1:0] last = ptr_w'(soc_pkg::fifo_depth - 1);

	logic [7:0]       mem [soc_pkg::fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             push;
	logic             pop;

	// serial input cannot stall, so a full fifo drops the byte
	assign push      = in_byte.valid && (count != cnt_w'(soc_pkg::fifo_depth));
	assign pop       = out_valid && out_ready;
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_byte.data;
	end

	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == last) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == last) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- src/hci_engine.sv
// ----------------------------------------------------------------------
// host engine, runs uart commands on the bus during a debug break and
// serves processor io writes to the transmitter
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module hci_engine
(
	input  logic              clk,
	input  logic              btnC,
	input  logic              cmd_valid,
	input  logic [7:0]        cmd_data,
	output logic              cmd_ready,
	output logic              active,
	output soc_pkg::mem_req_t hci_req,
	output logic              hci_en,
	input  logic [7:0]        ram_rdata,
	input  soc_pkg::mem_req_t io_req,
	input  logic              io_en,
	output logic [7:0]        io_rdata,
	output logic              io_stall,
	output logic              tx_valid,
	output logic [7:0]        tx_data,
	input  logic              tx_ready
);

	typedef enum logic [2:0] {
		s_opcode,
		s_addr0,
		s_addr1,
		s_addr2,
		s_data,
		s_access,
		s_capture,
		s_respond
	} state_t;

	state_t     state;
	logic [7:0] resp;
	logic       cmd_take;
	logic       tx_busy;
	logic       io_tx_hit;
	logic       io_take;
	logic       resp_take;

	assign cmd_ready = (state == s_opcode) || (state == s_addr0) || (state == s_addr1) ||
		(state == s_addr2) || (state == s_data);
	assign cmd_take  = cmd_valid && cmd_ready;
	assign hci_en    = (state == s_access);

	// transmitter is busy while a byte waits in tx_data or is shifting
	assign tx_busy   = tx_valid || !tx_ready;
	assign io_tx_hit = io_en && io_req.wr && (io_req.addr.io_view.sel == soc_pkg::io_sel_tx);
	assign io_stall  = io_tx_hit && tx_busy;
	assign io_take   = io_tx_hit && !tx_busy;
	// processor io write wins a tie with a host answer
	assign resp_take = (state == s_respond) && !tx_busy && !io_take;

	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			state  <= s_opcode;
			active <= 1'b0;
		end
		else
		begin
			case (state)
				s_opcode:
					if (cmd_take)
					begin
						case (cmd_data)
							soc_pkg::op_break:   active <= 1'b1;
							soc_pkg::op_release: active <= 1'b0;
							soc_pkg::op_read:    state  <= s_addr0;
							soc_pkg::op_write:   state  <= s_addr0;
							// unknown opcode, drop it
							default:             state  <= s_opcode;
						endcase
					end
				s_addr0:
					if (cmd_take)
						state <= s_addr1;
				s_addr1:
					if (cmd_take)
						state <= s_addr2;
				s_addr2:
					if (cmd_take)
						state <= hci_req.wr ? s_data : s_access;
				s_data:
					if (cmd_take)
						state <= s_access;
				s_access:
					state <= hci_req.wr ? s_opcode : s_capture;
				s_capture:
					state <= s_respond;
				default:
					if (resp_take)
						state <= s_opcode;
			endcase
		end
	end

	// address arrives low byte first
	always_ff @(posedge clk)
	begin
		if (cmd_take)
		begin
			case (state)
				s_opcode: hci_req.wr                           <= (cmd_data == soc_pkg::op_write);
				s_addr0:  hci_req.addr.ram_view.offset[7:0]    <= cmd_data;
				s_addr1:  hci_req.addr.ram_view.offset[15:8]   <= cmd_data;
				s_addr2:  hci_req.addr.io_view.region          <= cmd_data[1:0];
				default:  hci_req.data                         <= cmd_data;
			endcase
		end
		// ram answers one cycle after the access
		if (state == s_capture)
			resp <= ram_rdata;
	end

	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
			tx_valid <= 1'b0;
		else if (tx_valid && tx_ready)
			tx_valid <= 1'b0;
		else if (io_take || resp_take)
			tx_valid <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (io_take)
			tx_data <= io_req.data;
		else if (resp_take)
			tx_data <= resp;
		// status read gives the transmitter busy bit, other selects read zero
		if (io_en && !io_req.wr)
			io_rdata <= (io_req.addr.io_view.sel == soc_pkg::io_sel_status) ?
				{7'b0, tx_busy} : 8'h00;
	end

endmodule

//--- src/uart_tx.sv
// ----------------------------------------------------------------------
// uart transmitter, shifts one 8N1 frame per accepted byte
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module uart_tx
(
	input  logic       clk,
	input  logic       btnC,
	input  logic       tx_valid,
	input  logic [7:0] tx_data,
	output logic       tx_ready,
	output logic       tx
);

	localparam int cnt_w = $clog2(soc_pkg::clks_per_bit);
	localparam logic [cnt_w-1:0] full = cnt_w'(soc_pkg::clks_per_bit - 1);

	logic             busy;
	logic [9:0]       frame;
	logic [3:0]       bit_idx;
	logic [cnt_w-1:0] cnt;

	assign tx_ready = !busy;

	// stop, data lsb first, start
	always_ff @(posedge clk)
	begin
		if (!busy && tx_valid)
			frame <= {1'b1, tx_data, 1'b0};
		else if (busy && cnt == full)
			frame <= {1'b1, frame[9:1]};
	end

	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			busy    <= 1'b0;
			bit_idx <= '0;
			cnt     <= '0;
			tx      <= 1'b1;
		end
		else
		begin
			// registered line, idle high
			tx <= busy ? frame[0] : 1'b1;
			if (!busy)
			begin
				if (tx_valid)
				begin
					busy    <= 1'b1;
					bit_idx <= '0;
					cnt     <= '0;
				end
			end
			else if (cnt == full)
			begin
				cnt <= '0;
				if (bit_idx == 4'd9)
					busy <= 1'b0;
				else
					bit_idx <= bit_idx + 1'b1;
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- src/byte_ram.sv
// ----------------------------------------------------------------------
// single port byte ram, one cycle read latency
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module byte_ram
(
	input  logic                               clk,
	input  logic                               en,
	input  logic                               wr,
	input  logic [soc_pkg::ram_addr_width-1:0] addr,
	input  logic [7:0]                         wdata,
	output logic [7:0]                         rdata
);

	logic [7:0] mem [2**soc_pkg::ram_addr_width];

	// read returns the old byte on a write
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (wr)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

endmodule

//--- src/soc_top.sv
// ----------------------------------------------------------------------
// memory system top, reset sync, bus mux between processor port and
// host engine, ram and io region decode
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module soc_top
(
	input  logic              clk,
	input  logic              btnC,
	input  logic              rx,
	output logic              tx,
	output logic              led,
	input  soc_pkg::mem_req_t cpu_req,
	input  logic              cpu_en,
	output logic              cpu_rdy,
	output logic [7:0]        cpu_rdata
);

	logic                  rst_meta;
	logic                  rst;
	logic                  run;
	logic                  rd_io;
	soc_pkg::byte_stream_t rx_byte;
	logic                  cmd_valid;
	logic [7:0]            cmd_data;
	logic                  cmd_ready;
	logic                  hci_active;
	soc_pkg::mem_req_t     hci_req;
	logic                  hci_en;
	soc_pkg::mem_req_t     bus_req;
	logic                  bus_en;
	logic                  is_io;
	logic                  ram_en;
	logic                  io_en;
	logic [7:0]            ram_rdata;
	logic [7:0]            io_rdata;
	logic                  io_stall;
	logic                  tx_valid;
	logic [7:0]            tx_data;
	logic                  tx_ready;

	// two stage sync, released two clocks after btnC drops
	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			rst_meta <= 1'b1;
			rst      <= 1'b1;
		end
		else
		begin
			rst_meta <= 1'b0;
			rst      <= rst_meta;
		end
	end

	// run goes high the cycle after reset, rd_io steers the late read data
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			run   <= 1'b0;
			rd_io <= 1'b0;
		end
		else
		begin
			run <= 1'b1;
			if (bus_en)
				rd_io <= is_io;
		end
	end

	// engine owns the bus during a debug break
	assign bus_req = hci_active ? hci_req : cpu_req;
	assign bus_en  = hci_active ? hci_en : (cpu_en && run);
	assign is_io   = (bus_req.addr.io_view.region == 2'b11);
	assign ram_en  = bus_en && !is_io;
	assign io_en   = bus_en && is_io;

	assign led       = hci_active;
	assign cpu_rdy   = run && !hci_active && !io_stall;
	assign cpu_rdata = rd_io ? io_rdata : ram_rdata;

	uart_rx u_rx (.clk(clk), .btnC(rst), .rx(rx), .rx_byte(rx_byte));

	cmd_fifo u_fifo (
		.clk(clk), .btnC(rst), .in_byte(rx_byte),
		.out_valid(cmd_valid), .out_data(cmd_data), .out_ready(cmd_ready)
	);

	hci_engine u_hci (
		.clk(clk), .btnC(rst),
		.cmd_valid(cmd_valid), .cmd_data(cmd_data), .cmd_ready(cmd_ready),
		.active(hci_active), .hci_req(hci_req), .hci_en(hci_en), .ram_rdata(ram_rdata),
		.io_req(bus_req), .io_en(io_en), .io_rdata(io_rdata), .io_stall(io_stall),
		.tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready)
	);

	uart_tx u_tx (
		.clk(clk), .btnC(rst), .tx_valid(tx_valid), .tx_data(tx_data),
		.tx_ready(tx_ready), .tx(tx)
	);

	byte_ram u_ram (
		.clk(clk), .en(ram_en), .wr(bus_req.wr), .addr(bus_req.addr.ram_view.offset),
		.wdata(bus_req.data), .rdata(ram_rdata)
	);

endmodule

//--- test/soc_checker.sv
// ----------------------------------------------------------------------
// bus and serial line properties of the memory system top
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module soc_checker
(
	input logic clk,
	input logic rst,
	input logic led,
	input logic cpu_rdy,
	input logic tx,
	input logic ram_en,
	input logic io_en
);

	// processor port is paused for the whole break
	rdy_low_in_break: assert property (@(posedge clk) led |-> !cpu_rdy)
		else $error("cpu_rdy high while the break holds the bus");

	// line idles high until the internal reset lets go
	tx_idle_in_reset: assert property (@(posedge clk) rst |-> tx)
		else $error("tx left idle level during reset");

	one_target: assert property (@(posedge clk) !(ram_en && io_en))
		else $error("ram and io port enabled in the same cycle");

endmodule

bind soc_top soc_checker i_checker (
	.clk(clk), .rst(rst), .led(led), .cpu_rdy(cpu_rdy), .tx(tx),
	.ram_en(ram_en), .io_en(io_en)
);

//--- test/soc_tb.sv
// ----------------------------------------------------------------------
// testbench for soc_top, plays host over uart and processor on the bus
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module soc_tb;

	logic              clk;
	logic              btnC;
	logic              rx;
	logic              tx;
	logic              led;
	soc_pkg::mem_req_t cpu_req;
	logic              cpu_en;
	logic              cpu_rdy;
	logic [7:0]        cpu_rdata;

	// bytes still due on tx, oldest first
	logic [7:0] exp_q[$];
	int         mismatches;
	int         timeouts;
	int         others;

	soc_top i_dut (
		.clk(clk), .btnC(btnC), .rx(rx), .tx(tx), .led(led),
		.cpu_req(cpu_req), .cpu_en(cpu_en), .cpu_rdy(cpu_rdy), .cpu_rdata(cpu_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [7:0] got,
		input logic [7:0] want);
		$display("MISMATCH %s got %h expected %h", name, got, want);
		mismatches++;
	endtask

	function automatic int idle_gap(input bit spaced);
		return spaced ? int'($urandom % 12) : 0;
	endfunction

	// one 8N1 frame, lsb first
	task automatic send_byte(input logic [7:0] b, input int gap);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		@(posedge clk);
		#1;
		for (int i = 0; i < 10; i++)
		begin
			rx = frame[i];
			repeat (soc_pkg::clks_per_bit) @(posedge clk);
			#1;
		end
		repeat (gap) @(posedge clk);
	endtask

	task automatic host_cmd(input logic [7:0] opc, input logic [23:0] addr,
		input logic [7:0] data, input bit spaced);
		send_byte(opc, idle_gap(spaced));
		if (opc == soc_pkg::op_read || opc == soc_pkg::op_write)
		begin
			send_byte(addr[7:0], idle_gap(spaced));
			send_byte(addr[15:8], idle_gap(spaced));
			send_byte(addr[23:16], idle_gap(spaced));
		end
		if (opc == soc_pkg::op_write)
			send_byte(data, idle_gap(spaced));
	endtask

	task automatic wait_led(input logic val);
		int n;
		n = 0;
		@(negedge clk);
		while (led !== val && n < 200)
		begin
			n++;
			@(negedge clk);
		end
		assert (led === val) else
		begin
			$display("timeout: led did not change to %0d after the host command", val);
			timeouts++;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		@(negedge clk);
		while (exp_q.size() != 0 && n < 1500)
		begin
			n++;
			@(negedge clk);
		end
		assert (exp_q.size() == 0) else
		begin
			$display("timeout: %0d answer bytes never showed up on tx", exp_q.size());
			timeouts++;
		end
	endtask

	// read data is sampled one cycle after the accepting edge
	task automatic cpu_access(input logic [23:0] addr, input logic wr, input logic [7:0] data,
		output logic [7:0] rdata, output int stall);
		int n;
		n = 0;
		@(posedge clk);
		#1;
		cpu_req.addr = addr[17:0];
		cpu_req.wr   = wr;
		cpu_req.data = data;
		cpu_en       = 1'b1;
		@(negedge clk);
		while (cpu_rdy !== 1'b1 && n < 400)
		begin
			n++;
			@(negedge clk);
		end
		stall = n;
		assert (cpu_rdy === 1'b1) else
		begin
			$display("timeout: processor access at %h was never accepted", addr);
			timeouts++;
		end
		@(posedge clk);
		#1;
		cpu_en = 1'b0;
		@(negedge clk);
		rdata = cpu_rdata;
	endtask

	// processor write presented during a break, freed by the release
	task automatic hold_across_release(input logic [23:0] addr, input logic [7:0] data);
		int n;
		n = 0;
		assert (led === 1'b1) else
		begin
			$display("held write requested while no break was in place");
			others++;
		end
		@(posedge clk);
		#1;
		cpu_req.addr = addr[17:0];
		cpu_req.wr   = 1'b1;
		cpu_req.data = data;
		cpu_en       = 1'b1;
		fork
			host_cmd(soc_pkg::op_release, 24'h0, 8'h00, 1'b1);
			begin
				@(negedge clk);
				while (cpu_rdy !== 1'b1 && n < 1000)
				begin
					n++;
					@(negedge clk);
				end
				assert (cpu_rdy === 1'b1) else
				begin
					$display("timeout: held write was not accepted after the release");
					timeouts++;
				end
				assert (led === 1'b0) else
				begin
					$display("held write was accepted while the break was still on");
					others++;
				end
				// release cannot land before its data bits are in
				assert (n >= 8 * soc_pkg::clks_per_bit) else
				begin
					$display("held write went through after only %0d cycles", n);
					others++;
				end
				@(posedge clk);
				#1;
				cpu_en = 1'b0;
			end
		join
	endtask

	task automatic run_op(input logic [63:0] op, input logic [23:0] a, input logic [7:0] d);
		logic [7:0] rd;
		int         stall;
		int         pending;
		case (op)
			"hb":
			begin
				host_cmd(soc_pkg::op_break, 24'h0, 8'h00, 1'b1);
				wait_led(1'b1);
			end
			"hl":
			begin
				host_cmd(soc_pkg::op_release, 24'h0, 8'h00, 1'b1);
				wait_led(1'b0);
			end
			"hw":  host_cmd(soc_pkg::op_write, a, d, 1'b1);
			"hwn": host_cmd(soc_pkg::op_write, a, d, 1'b0);
			"hr":
			begin
				exp_q.push_back(d);
				host_cmd(soc_pkg::op_read, a, 8'h00, 1'b1);
				wait_drain();
			end
			"hrn":
			begin
				exp_q.push_back(d);
				host_cmd(soc_pkg::op_read, a, 8'h00, 1'b0);
			end
			"sy":  wait_drain();
			"pw":  cpu_access(a, 1'b1, d, rd, stall);
			"pr":
			begin
				cpu_access(a, 1'b0, 8'h00, rd, stall);
				assert (rd === d) else
					report_mismatch("cpu_rdata", rd, d);
			end
			"ph":  hold_across_release(a, d);
			"pt":
			begin
				pending = exp_q.size();
				cpu_access(a, 1'b1, d, rd, stall);
				// a busy transmitter holds the second write off until the first byte is out
				if (pending != 0)
				begin
					assert (stall > 0) else
					begin
						$display("io write was not stalled behind a busy transmitter");
						others++;
					end
					assert (exp_q.size() == 0) else
					begin
						$display("io write accepted before the previous byte left tx");
						others++;
					end
				end
				exp_q.push_back(d);
			end
			default:
			begin
				$display("unknown operation in the test data file");
				others++;
			end
		endcase
	endtask

	// decodes tx mid-bit and checks against the expected queue
	initial
	begin : tx_monitor
		logic [7:0] b;
		logic [7:0] want;
		forever
		begin
			@(negedge clk);
			if (tx === 1'b0)
			begin
				repeat (soc_pkg::clks_per_bit / 2) @(negedge clk);
				assert (tx === 1'b0) else
				begin
					$display("start bit on tx ended early");
					others++;
				end
				for (int i = 0; i < 8; i++)
				begin
					repeat (soc_pkg::clks_per_bit) @(negedge clk);
					b[i] = tx;
				end
				repeat (soc_pkg::clks_per_bit) @(negedge clk);
				assert (tx === 1'b1) else
				begin
					$display("no stop bit after byte %h on tx", b);
					others++;
				end
				if (exp_q.size() == 0)
				begin
					$display("byte %h on tx was not expected", b);
					others++;
				end
				else
				begin
					want = exp_q.pop_front();
					assert (b === want) else
						report_mismatch("tx", b, want);
				end
			end
		end
	end

	initial
	begin
		int          fd;
		int          n;
		string       line;
		logic [63:0] op;
		logic [23:0] a;
		logic [7:0]  d;
		btnC       = 1'b1;
		rx         = 1'b1;
		cpu_en     = 1'b0;
		cpu_req    = '0;
		mismatches = 0;
		timeouts   = 0;
		others     = 0;
		void'($urandom(32'hcf0c));
		repeat (5) @(posedge clk);
		#1;
		btnC = 1'b0;
		@(negedge clk);
		assert (led === 1'b0) else
			report_mismatch("led", 8'(led), 8'h00);
		assert (tx === 1'b1) else
			report_mismatch("tx", 8'(tx), 8'h01);
		n = 0;
		while (cpu_rdy !== 1'b1 && n < 20)
		begin
			n++;
			@(negedge clk);
		end
		assert (cpu_rdy === 1'b1) else
		begin
			$display("timeout: cpu_rdy did not rise after reset");
			timeouts++;
		end

		fd = $fopen("test/soc_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test data file");
			others++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#")
				begin
					a = '0;
					d = '0;
					n = $sscanf(line, "%s %h %h", op, a, d);
					if (n < 1)
					begin
						$display("unreadable line in the test data file");
						others++;
					end
					else
						run_op(op, a, d);
				end
			end
			$fclose(fd);
		end

		wait_drain();
		repeat (20) @(posedge clk);
		$display("errors: %0d mismatch, %0d timeout, %0d other", mismatches, timeouts, others);
		if (mismatches + timeouts + others == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- all.f
src/soc_pkg.sv
src/uart_rx.sv
src/cmd_fifo.sv
src/hci_engine.sv
src/uart_tx.sv
src/byte_ram.sv
src/soc_top.sv
test/soc_checker.sv
test/soc_tb.sv

//--- Makefile
# Verilator build and run for the memory system testbench

VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Test passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the log holds the pass line
test: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/soc_tests.txt
# columns: op addr data, hex. data is the byte to write or the byte expected back
# ops: hb break, hl release, hw/hr host write/read, hwn/hrn same with no gaps
# sy wait for tx answers, pw/pr processor write/read, ph held write, pt io transmit
pw 00010 a5
pr 00010 a5
pw 1fffe 3c
pr 1fffe 3c
hb 0 0
ph 00020 77
pr 00020 77
hb 0 0
hw 00123 5e
hr 00123 5e
hw 10456 c3
hr 10456 c3
# byte from the processor side, read by the host
hr 00010 a5
hl 0 0
pr 10456 c3
pt 30000 41
pt 30000 42
sy 0 0
hb 0 0
hwn 00200 11
hwn 00201 22
hrn 00200 11
hrn 00201 22
hrn 1fffe 3c
hwn 00202 33
hrn 00202 33
sy 0 0
hl 0 0
pr 00202 33
# status select, transmitter idle
pr 30001 00
